// File: src/tc_params.svh
`ifndef TC_PARAMS_SVH
`define TC_PARAMS_SVH

// lanes per warp, multiple of 8 (one octet per 8 lanes)
`define TC_NUM_LANES 16
// warps sharing the unit
`define TC_NUM_WARPS 4
// data word width
`define TC_XLEN 32

// dot-product pipeline depth
`define TC_DPU_LATENCY 4
// result buffer absorbs a full pipeline burst twice over
`define TC_OUTBUF_DEPTH (2 * `TC_DPU_LATENCY)
// metadata entries per warp, two pairs of two
`define TC_META_DEPTH 4

// bookkeeping field widths
`define TC_UUID_W 8
`define TC_RD_W 5

`endif

// File: src/tc_pkg.sv
`include "tc_params.svh"

package tc_pkg;

    // one octet per 8 lanes
    localparam int NUM_OCTETS = `TC_NUM_LANES / 8;
    // second threadgroup of an octet sits this many lanes higher
    localparam int TG_OFFSET = `TC_NUM_LANES / 2;

    typedef logic [`TC_XLEN-1:0] word_t;
    typedef word_t [`TC_NUM_LANES-1:0] lane_vec_t;
    typedef word_t [7:0] octet_vec_t;

    // operand halves picked out of an octet by the step field
    typedef word_t [3:0] half_a_t;
    typedef word_t [3:0] half_b_t;

    // a indexed [m][k], b indexed [k][n], c and d indexed [row][col]
    typedef word_t [3:0][1:0] tile_a_t;
    typedef word_t [1:0][3:0] tile_b_t;
    typedef word_t [3:0][3:0] tile_t;

    typedef logic [$clog2(`TC_NUM_WARPS)-1:0] wid_t;
    typedef logic [1:0] step_t;

    typedef struct packed {
        logic [`TC_UUID_W-1:0] uuid;
        logic [`TC_RD_W-1:0]   rd;
    } meta_t;

    typedef struct packed {
        wid_t  wid;
        tile_t tile;
    } result_t;

endpackage

// File: src/tc_operand_if.sv
`timescale 1ns/1ps

interface tc_operand_if;
    import tc_pkg::*;

    logic       valid;
    wid_t       wid;
    step_t      step;
    // 0 for the first instruction of a pair, 1 for the last
    logic       last;
    // octet lanes 0..3 from the low threadgroup, 4..7 from the high one
    octet_vec_t a;
    octet_vec_t b;
    octet_vec_t c;
    logic       ready;

    modport feeder (output valid, wid, step, last, a, b, c, input ready);
    modport octet (input valid, wid, step, last, a, b, c, output ready);

endinterface

// File: src/tc_result_if.sv
`timescale 1ns/1ps

interface tc_result_if;
    import tc_pkg::*;

    logic  valid;
    wid_t  wid;
    // full 4x4 result, written back over two beats
    tile_t tile;
    // raised only once both beats have gone out
    logic  ready;

    modport octet (output valid, wid, tile, input ready);
    modport commit (input valid, wid, tile, output ready);

endinterface

// File: src/tc_fifo.sv
`timescale 1ns/1ps

module tc_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int  DEPTH     = 4
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     push,
    input  logic     pop,
    input  payload_t din,
    output payload_t dout,
    output logic     empty,
    output logic     full
);
    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    payload_t mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [CW-1:0] count;

    assign empty = (count == '0);
    assign full  = (count == CW'(DEPTH));
    // head entry is always on the output
    assign dout  = mem[rd_ptr];

    // storage is written only on push
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= din;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            // explicit pointer wrap so depth need not be a power of two
            if (push) begin
                wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + CW'(push) - CW'(pop);
        end
    end

    a_no_overflow: assert property (@(posedge clk) disable iff (reset) push |-> !full)
        else $error("tc_fifo: push while full");
    a_no_underflow: assert property (@(posedge clk) disable iff (reset) pop |-> !empty)
        else $error("tc_fifo: pop while empty");

endmodule

// File: src/tc_dpu.sv
`timescale 1ns/1ps

`include "tc_params.svh"

module tc_dpu (
    input  logic             clk,
    input  logic             reset,
    input  logic             in_valid,
    output logic             in_ready,
    input  tc_pkg::tile_a_t  a,
    input  tc_pkg::tile_b_t  b,
    input  tc_pkg::tile_t    c,
    input  tc_pkg::wid_t     in_wid,
    output logic             out_valid,
    input  logic             out_ready,
    output tc_pkg::tile_t    d,
    output tc_pkg::wid_t     out_wid
);
    import tc_pkg::*;

    localparam int LAT = `TC_DPU_LATENCY;

    tile_t d_comb;
    logic  stall;

    logic [LAT-1:0] stage_valid;
    tile_t stage_d [LAT];
    wid_t  stage_wid [LAT];

    // 4x4x2 product plus accumulator with 32-bit wraparound
    always_comb begin
        for (int row = 0; row < 4; row++) begin
            for (int col = 0; col < 4; col++) begin
                d_comb[row][col] = a[row][0] * b[0][col] + a[row][1] * b[1][col] + c[row][col];
            end
        end
    end

    // whole pipe freezes while the last stage is refused
    assign stall    = stage_valid[LAT-1] && !out_ready;
    assign in_ready = !stall;

    always_ff @(posedge clk) begin
        if (reset) begin
            stage_valid <= '0;
        end else if (!stall) begin
            stage_valid[0] <= in_valid;
            for (int s = 1; s < LAT; s++) begin
                stage_valid[s] <= stage_valid[s-1];
            end
        end
    end

    // payload stages qualified by stage_valid
    always_ff @(posedge clk) begin
        if (!stall) begin
            stage_d[0]   <= d_comb;
            stage_wid[0] <= in_wid;
            for (int s = 1; s < LAT; s++) begin
                stage_d[s]   <= stage_d[s-1];
                stage_wid[s] <= stage_wid[s-1];
            end
        end
    end

    assign out_valid = stage_valid[LAT-1];
    assign d         = stage_d[LAT-1];
    assign out_wid   = stage_wid[LAT-1];

endmodule

// File: src/tc_octet.sv
`timescale 1ns/1ps

`include "tc_params.svh"

module tc_octet (
    input  logic         clk,
    input  logic         reset,
    tc_operand_if.octet  ops,
    tc_result_if.octet   res
);
    import tc_pkg::*;

    localparam int NW = `TC_NUM_WARPS;

    // halves of the current instruction, chosen by step
    half_a_t cur_a;
    half_b_t cur_b;

    // first-instruction state, one slot per warp
    half_a_t    a_buf [NW];
    half_b_t    b_buf [NW];
    octet_vec_t c_buf [NW];
    logic [NW-1:0] pending;

    logic first_fire;
    logic last_fire;

    tile_a_t tile_a;
    tile_b_t tile_b;
    tile_t   tile_c;

    logic    dpu_ready;
    logic    dpu_valid;
    tile_t   dpu_d;
    wid_t    dpu_wid;

    result_t outbuf_din;
    result_t outbuf_dout;
    logic    outbuf_empty;
    logic    outbuf_full;
    logic    outbuf_push;
    logic    outbuf_pop;

    // A lanes {0,1,4,5}, shifted by 2 on step bit 0
    // B lanes 0..3, shifted by 4 on step bit 1
    always_comb begin
        for (int m = 0; m < 4; m++) begin
            cur_a[m] = ops.a[(m % 2) + 4 * (m / 2) + (ops.step[0] ? 2 : 0)];
        end
        for (int n = 0; n < 4; n++) begin
            cur_b[n] = ops.b[n + (ops.step[1] ? 4 : 0)];
        end
    end

    // ready only reflects the dpu, first halves never stall
    assign ops.ready  = dpu_ready;
    assign first_fire = ops.valid && ops.ready && !ops.last;
    assign last_fire  = ops.valid && ops.ready && ops.last;

    always_ff @(posedge clk) begin
        if (first_fire) begin
            a_buf[ops.wid] <= cur_a;
            b_buf[ops.wid] <= cur_b;
            c_buf[ops.wid] <= ops.c;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pending <= '0;
        end else begin
            if (first_fire) begin
                pending[ops.wid] <= 1'b1;
            end
            if (last_fire) begin
                pending[ops.wid] <= 1'b0;
            end
        end
    end

    // k=0 comes from the buffer, k=1 straight off the operand bus
    always_comb begin
        for (int m = 0; m < 4; m++) begin
            tile_a[m][0] = a_buf[ops.wid][m];
            tile_a[m][1] = cur_a[m];
        end
        tile_b[0] = b_buf[ops.wid];
        tile_b[1] = cur_b;
        // even columns of C from the first instruction, odd from the last
        for (int row = 0; row < 4; row++) begin
            for (int col = 0; col < 4; col++) begin
                if (col % 2 == 1) begin
                    tile_c[row][col] = ops.c[4 * (row / 2) + (row % 2) + 2 * (col / 2)];
                end else begin
                    tile_c[row][col] = c_buf[ops.wid][4 * (row / 2) + (row % 2) + 2 * (col / 2)];
                end
            end
        end
    end

    tc_dpu i_tc_dpu (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (ops.valid && ops.last),
        .in_ready  (dpu_ready),
        .a         (tile_a),
        .b         (tile_b),
        .c         (tile_c),
        .in_wid    (ops.wid),
        .out_valid (dpu_valid),
        .out_ready (!outbuf_full),
        .d         (dpu_d),
        .out_wid   (dpu_wid)
    );

    // result buffer decouples dpu bursts from two-beat writeback
    assign outbuf_din  = '{wid: dpu_wid, tile: dpu_d};
    assign outbuf_push = dpu_valid && !outbuf_full;
    assign outbuf_pop  = res.valid && res.ready;

    tc_fifo #(
        .payload_t (result_t),
        .DEPTH     (`TC_OUTBUF_DEPTH)
    ) i_outbuf (
        .clk   (clk),
        .reset (reset),
        .push  (outbuf_push),
        .pop   (outbuf_pop),
        .din   (outbuf_din),
        .dout  (outbuf_dout),
        .empty (outbuf_empty),
        .full  (outbuf_full)
    );

    assign res.valid = !outbuf_empty;
    assign res.wid   = outbuf_dout.wid;
    assign res.tile  = outbuf_dout.tile;

    // the last of a pair needs its first half already buffered
    a_pair_order: assert property (@(posedge clk) disable iff (reset)
        last_fire |-> pending[ops.wid])
        else $error("tc_octet: last-in-pair without a buffered first half");

endmodule

// File: src/tc_warp.sv
`timescale 1ns/1ps

`include "tc_params.svh"

module tc_warp (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  in_valid,
    output logic                  in_ready,
    input  tc_pkg::wid_t          in_wid,
    input  tc_pkg::step_t         in_step,
    input  logic                  in_last,
    input  logic [`TC_UUID_W-1:0] in_uuid,
    input  logic [`TC_RD_W-1:0]   in_rd,
    input  tc_pkg::lane_vec_t     in_rs1,
    input  tc_pkg::lane_vec_t     in_rs2,
    input  tc_pkg::lane_vec_t     in_rs3,
    output logic                  out_valid,
    input  logic                  out_ready,
    output tc_pkg::wid_t          out_wid,
    output logic [`TC_UUID_W-1:0] out_uuid,
    output logic [`TC_RD_W-1:0]   out_rd,
    output logic                  out_half,
    output tc_pkg::lane_vec_t     out_data
);
    import tc_pkg::*;

    localparam int NW = `TC_NUM_WARPS;

    logic [NUM_OCTETS-1:0] oct_ready;
    logic [NUM_OCTETS-1:0] oct_valid;
    wid_t oct_wid [NUM_OCTETS];

    logic in_fire;
    logic out_fire;
    // tile retires only after its second beat
    logic res_pop;

    meta_t meta_in;
    meta_t meta_head [NW];
    logic [NW-1:0] meta_empty;
    logic [NW-1:0] meta_full;

    // all octets must agree before an instruction goes in
    assign in_ready = &oct_ready;
    assign in_fire  = in_valid && in_ready;
    assign out_fire = out_valid && out_ready;
    assign res_pop  = out_fire && out_half;

    for (genvar i = 0; i < NUM_OCTETS; i++) begin : g_octet
        tc_operand_if ops_if ();
        tc_result_if  res_if ();

        // octet lanes 0..3 from 4i, lanes 4..7 from the upper threadgroup
        assign ops_if.valid = in_valid;
        assign ops_if.wid   = in_wid;
        assign ops_if.step  = in_step;
        assign ops_if.last  = in_last;
        assign ops_if.a     = {in_rs1[TG_OFFSET + 4*i +: 4], in_rs1[4*i +: 4]};
        assign ops_if.b     = {in_rs2[TG_OFFSET + 4*i +: 4], in_rs2[4*i +: 4]};
        assign ops_if.c     = {in_rs3[TG_OFFSET + 4*i +: 4], in_rs3[4*i +: 4]};
        assign oct_ready[i] = ops_if.ready;

        tc_octet i_tc_octet (
            .clk   (clk),
            .reset (reset),
            .ops   (ops_if.octet),
            .res   (res_if.octet)
        );

        assign oct_valid[i] = res_if.valid;
        assign oct_wid[i]   = res_if.wid;
        assign res_if.ready = res_pop;

        // beat h takes columns h and h+2; rows 0,1 low lanes, rows 2,3 high lanes
        for (genvar j = 0; j < 4; j++) begin : g_lane
            assign out_data[4*i + j] =
                res_if.tile[j % 2][2 * (j / 2) + int'(out_half)];
            assign out_data[TG_OFFSET + 4*i + j] =
                res_if.tile[2 + j % 2][2 * (j / 2) + int'(out_half)];
        end

        // octets retire in lockstep, same tile order everywhere
        a_lockstep: assert property (@(posedge clk) disable iff (reset)
            res_if.valid == oct_valid[0] && (!res_if.valid || res_if.wid == oct_wid[0]))
            else $error("tc_warp: octet %0d out of lockstep", i);
    end

    assign out_valid = &oct_valid;
    assign out_wid   = oct_wid[0];

    // beat toggle, first beat after reset is 0
    always_ff @(posedge clk) begin
        if (reset) begin
            out_half <= 1'b0;
        end else if (out_fire) begin
            out_half <= ~out_half;
        end
    end

    // per-warp queues keep a pair's two entries back to back
    assign meta_in = '{uuid: in_uuid, rd: in_rd};

    for (genvar w = 0; w < NW; w++) begin : g_meta
        tc_fifo #(
            .payload_t (meta_t),
            .DEPTH     (`TC_META_DEPTH)
        ) i_meta_q (
            .clk   (clk),
            .reset (reset),
            .push  (in_fire && in_wid == wid_t'(w)),
            .pop   (out_fire && out_wid == wid_t'(w)),
            .din   (meta_in),
            .dout  (meta_head[w]),
            .empty (meta_empty[w]),
            .full  (meta_full[w])
        );
    end

    assign out_uuid = meta_head[out_wid].uuid;
    assign out_rd   = meta_head[out_wid].rd;

    // every result beat has bookkeeping waiting for it
    a_meta_present: assert property (@(posedge clk) disable iff (reset)
        out_valid |-> !meta_empty[out_wid])
        else $error("tc_warp: result beat without metadata");

    // at most two pairs in flight per warp
    a_outstanding: assert property (@(posedge clk) disable iff (reset)
        in_fire |-> !meta_full[in_wid])
        else $error("tc_warp: too many outstanding pairs for warp %0d", in_wid);

endmodule

// File: tb/tc_tb.sv
`timescale 1ns/1ps

`include "tc_params.svh"

module tc_tb;
    import tc_pkg::*;

    localparam int NW = `TC_NUM_WARPS;
    localparam int UW = `TC_UUID_W;
    localparam int RW = `TC_RD_W;
    localparam int LW = $clog2(`TC_NUM_LANES);
    localparam int VW = $bits(lane_vec_t);
    // cycle limits for each kind of wait
    localparam int READY_TIMEOUT = 200;
    localparam int ROOM_TIMEOUT  = 400;
    localparam int DRAIN_TIMEOUT = 1000;

    typedef logic [LW-1:0] lane_idx_t;

    // one expected writeback beat
    typedef struct packed {
        wid_t          wid;
        logic [UW-1:0] uuid;
        logic [RW-1:0] rd;
        logic          half;
        lane_vec_t     data;
    } beat_t;

    logic          clk = 1'b0;
    logic          reset;
    logic          in_valid;
    logic          in_ready;
    wid_t          in_wid;
    step_t         in_step;
    logic          in_last;
    logic [UW-1:0] in_uuid;
    logic [RW-1:0] in_rd;
    lane_vec_t     in_rs1;
    lane_vec_t     in_rs2;
    lane_vec_t     in_rs3;
    logic          out_valid;
    logic          out_ready;
    wid_t          out_wid;
    logic [UW-1:0] out_uuid;
    logic [RW-1:0] out_rd;
    logic          out_half;
    lane_vec_t     out_data;

    // reference model state holding the first instruction of each warp's open pair
    lane_vec_t     first_rs1 [NW];
    lane_vec_t     first_rs2 [NW];
    lane_vec_t     first_rs3 [NW];
    step_t         first_step [NW];
    logic [UW-1:0] first_uuid [NW];
    logic [RW-1:0] first_rd [NW];
    logic          has_first [NW];
    // metadata entries per warp not yet retired by a beat
    int            outstanding [NW];
    beat_t         exp_q [$];
    int            pairs_sent = 0;
    int            beats_checked = 0;
    // 0 always ready, 1 random, 2 held low
    int            ready_mode = 0;
    logic [UW-1:0] uuid_next = '0;

    always #50 clk = ~clk;

    tc_warp i_tc_warp (.*);

    // a refused beat must hold every field
    a_hold_stalled: assert property (@(posedge clk) disable iff (reset)
        out_valid && !out_ready |=> out_valid && $stable(out_data) && $stable(out_wid)
            && $stable(out_uuid) && $stable(out_rd) && $stable(out_half))
        else abort_run("outputs changed while out_ready was low");

    task automatic value_mismatch(input string name, input logic [VW-1:0] expected,
                                  input logic [VW-1:0] actual);
        $display("FAIL %s expected %0h actual %0h", name, expected, actual);
        $display("SOME TESTS FAILED");
        $fatal(1);
    endtask

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("SOME TESTS FAILED");
        $fatal(1);
    endtask

    // maps octet lane j of octet oct to its warp lane in either threadgroup
    function automatic lane_idx_t warp_lane(input int oct, input int j);
        int l;
        if (j < 4) begin
            l = 4 * oct + j;
        end else begin
            l = TG_OFFSET + 4 * oct + j - 4;
        end
        return lane_idx_t'(l);
    endfunction

    // a-half element m reads octet lane 0, 1, 4 or 5 plus 2 on step bit 0
    function automatic int a_lane(input int m, input step_t st);
        int base;
        case (m)
            0: base = 0;
            1: base = 1;
            2: base = 4;
            default: base = 5;
        endcase
        return base + (st[0] ? 2 : 0);
    endfunction

    function automatic lane_vec_t random_vec();
        lane_vec_t v;
        for (int l = 0; l < `TC_NUM_LANES; l++) begin
            v[lane_idx_t'(l)] = $urandom();
        end
        return v;
    endfunction

    // D = A*B + C per octet split into two beats of columns h and h+2
    task automatic model_pair(input wid_t wid, input step_t st, input logic [UW-1:0] uuid,
                              input logic [RW-1:0] rd, input lane_vec_t rs1,
                              input lane_vec_t rs2, input lane_vec_t rs3);
        word_t     av [2][4];
        word_t     bv [2][4];
        word_t     cv;
        word_t     d [4][4];
        lane_vec_t data [2];
        beat_t     bt;
        data[0] = '0;
        data[1] = '0;
        for (int i = 0; i < NUM_OCTETS; i++) begin
            for (int m = 0; m < 4; m++) begin
                av[0][m] = first_rs1[wid][warp_lane(i, a_lane(m, first_step[wid]))];
                av[1][m] = rs1[warp_lane(i, a_lane(m, st))];
                bv[0][m] = first_rs2[wid][warp_lane(i, m + (first_step[wid][1] ? 4 : 0))];
                bv[1][m] = rs2[warp_lane(i, m + (st[1] ? 4 : 0))];
            end
            for (int r = 0; r < 4; r++) begin
                for (int c = 0; c < 4; c++) begin
                    // even columns from the first instruction, odd from the last
                    if (c % 2 == 0) begin
                        cv = first_rs3[wid][warp_lane(i, 4 * (r / 2) + r % 2 + 2 * (c / 2))];
                    end else begin
                        cv = rs3[warp_lane(i, 4 * (r / 2) + r % 2 + 2 * (c / 2))];
                    end
                    d[r][c] = av[0][r] * bv[0][c] + av[1][r] * bv[1][c] + cv;
                end
            end
            for (int h = 0; h < 2; h++) begin
                for (int jj = 0; jj < 8; jj++) begin
                    data[h][warp_lane(i, jj)] = d[2 * (jj / 4) + jj % 2][h + 2 * ((jj % 4) / 2)];
                end
            end
        end
        // beat 0 belongs to the first instruction, beat 1 to the last
        bt.wid  = wid;
        bt.uuid = first_uuid[wid];
        bt.rd   = first_rd[wid];
        bt.half = 1'b0;
        bt.data = data[0];
        exp_q.push_back(bt);
        bt.uuid = uuid;
        bt.rd   = rd;
        bt.half = 1'b1;
        bt.data = data[1];
        exp_q.push_back(bt);
        pairs_sent++;
    endtask

    // drive one instruction, hold it until accepted, then feed the model
    task automatic issue(input wid_t wid, input step_t st, input logic last);
        lane_vec_t     rs1;
        lane_vec_t     rs2;
        lane_vec_t     rs3;
        logic [RW-1:0] rd;
        int            waited;
        rs1      = random_vec();
        rs2      = random_vec();
        rs3      = random_vec();
        rd       = RW'($urandom());
        in_valid = 1'b1;
        in_wid   = wid;
        in_step  = st;
        in_last  = last;
        in_uuid  = uuid_next;
        in_rd    = rd;
        in_rs1   = rs1;
        in_rs2   = rs2;
        in_rs3   = rs3;
        waited   = 0;
        @(negedge clk);
        while (in_ready !== 1'b1) begin
            if (waited == READY_TIMEOUT) abort_run("timed out waiting for in_ready");
            waited++;
            @(negedge clk);
        end
        // transfer happens on the coming edge
        outstanding[wid]++;
        has_first[wid] = !last;
        if (!last) begin
            first_rs1[wid]  = rs1;
            first_rs2[wid]  = rs2;
            first_rs3[wid]  = rs3;
            first_step[wid] = st;
            first_uuid[wid] = uuid_next;
            first_rd[wid]   = rd;
        end else begin
            model_pair(wid, st, uuid_next, rd, rs1, rs2, rs3);
        end
        uuid_next++;
        @(posedge clk);
        #1;
        in_valid = 1'b0;
    endtask

    // at most two pairs per warp may be in flight
    task automatic wait_room(input wid_t w);
        int waited;
        waited = 0;
        while (outstanding[w] > 2) begin
            if (waited == ROOM_TIMEOUT) abort_run("timed out waiting for a warp to retire a pair");
            waited++;
            @(posedge clk);
            #1;
        end
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (exp_q.size() > 0) begin
            if (waited == DRAIN_TIMEOUT) abort_run("timed out waiting for results to drain");
            waited++;
            @(posedge clk);
            #1;
        end
    endtask

    // random warps where each open pair closes before the warp starts another
    task automatic random_traffic(input int n_instr);
        wid_t w;
        for (int k = 0; k < n_instr; k++) begin
            w = wid_t'($urandom_range(0, NW - 1));
            if (has_first[w]) begin
                issue(w, step_t'($urandom_range(0, 3)), 1'b1);
            end else begin
                wait_room(w);
                issue(w, step_t'($urandom_range(0, 3)), 1'b0);
            end
        end
        for (int v = 0; v < NW; v++) begin
            if (has_first[v]) issue(wid_t'(v), step_t'($urandom_range(0, 3)), 1'b1);
        end
    endtask

    // out_ready picked mid-cycle and applied just after the edge
    task automatic drive_ready();
        logic next;
        forever begin
            @(negedge clk);
            case (ready_mode)
                0: next = 1'b1;
                1: next = ($urandom_range(0, 3) != 0);
                default: next = 1'b0;
            endcase
            @(posedge clk);
            #1;
            out_ready = next;
        end
    endtask

    // scoreboard comparing beats in order of last-in-pair acceptance
    task automatic check_beats();
        beat_t e;
        forever begin
            @(negedge clk);
            if (!reset && out_valid && out_ready) begin
                assert (exp_q.size() > 0) else abort_run("result beat with nothing expected");
                e = exp_q.pop_front();
                assert (out_wid === e.wid)
                    else value_mismatch("out_wid", VW'(e.wid), VW'(out_wid));
                assert (out_half === e.half)
                    else value_mismatch("out_half", VW'(e.half), VW'(out_half));
                assert (out_uuid === e.uuid)
                    else value_mismatch("out_uuid", VW'(e.uuid), VW'(out_uuid));
                assert (out_rd === e.rd) else value_mismatch("out_rd", VW'(e.rd), VW'(out_rd));
                assert (out_data === e.data) else value_mismatch("out_data", e.data, out_data);
                beats_checked++;
                outstanding[e.wid]--;
            end
        end
    endtask

    initial begin
        void'($urandom(32'hd032be1a));
        reset     = 1'b1;
        in_valid  = 1'b0;
        in_wid    = '0;
        in_step   = '0;
        in_last   = 1'b0;
        in_uuid   = '0;
        in_rd     = '0;
        in_rs1    = '0;
        in_rs2    = '0;
        in_rs3    = '0;
        out_ready = 1'b1;
        for (int w = 0; w < NW; w++) begin
            has_first[w]   = 1'b0;
            outstanding[w] = 0;
        end
        fork
            drive_ready();
            check_beats();
        join_none
        repeat (5) @(posedge clk);
        #1;
        reset = 1'b0;

        // idle after reset
        @(negedge clk);
        assert (out_valid === 1'b0) else value_mismatch("out_valid", VW'(0), VW'(out_valid));
        assert (in_ready === 1'b1) else value_mismatch("in_ready", VW'(1), VW'(in_ready));
        @(posedge clk);
        #1;

        // single pairs on warp 0 with every step value
        for (int s = 0; s < 4; s++) begin
            issue(wid_t'(0), step_t'(s), 1'b0);
            issue(wid_t'(0), step_t'(s), 1'b1);
            wait_drain();
        end

        // interleaved warps with the sink always ready
        random_traffic(60);
        wait_drain();

        // random back-pressure
        ready_mode = 1;
        random_traffic(120);
        wait_drain();

        // sustained stall with every warp at its two-pair limit
        ready_mode = 2;
        @(posedge clk);
        #1;
        for (int r = 0; r < 2; r++) begin
            for (int w = 0; w < NW; w++) begin
                wait_room(wid_t'(w));
                issue(wid_t'(w), step_t'($urandom_range(0, 3)), 1'b0);
                issue(wid_t'(w), step_t'($urandom_range(0, 3)), 1'b1);
            end
        end
        // metadata limit keeps tiles in flight within the result buffer depth
        repeat (20) begin
            @(posedge clk);
            #1;
        end
        assert (out_valid === 1'b1) else value_mismatch("out_valid", VW'(1), VW'(out_valid));
        ready_mode = 0;
        wait_drain();

        // every pair must give exactly two beats with none left over
        if (beats_checked == 2 * pairs_sent && exp_q.size() == 0) begin
            $display("ALL TESTS PASSED");
            $finish;
        end else begin
            value_mismatch("beats_checked", VW'(2 * pairs_sent), VW'(beats_checked));
        end
    end

endmodule

// File: files.f
+incdir+src
src/tc_pkg.sv
src/tc_operand_if.sv
src/tc_result_if.sv
src/tc_fifo.sv
src/tc_dpu.sv
src/tc_octet.sv
src/tc_warp.sv
tb/tc_tb.sv

// File: Makefile
# Verilator build and run for the tensor-core execute unit

VERILATOR ?= verilator
TOP       ?= tc_tb
OBJ_DIR   ?= obj_dir
FLIST     ?= files.f
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0

SIM  := $(OBJ_DIR)/V$(TOP)
SRCS := $(filter-out +%,$(shell cat $(FLIST)))
HDRS := $(wildcard src/*.svh)

.PHONY: all run clean

all: $(SIM)

# rebuilt only when a source, header or the file list changes
$(SIM): $(FLIST) $(SRCS) $(HDRS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

# exit status of the simulator is the test result
run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)
